/* spi_bridge_consts.svh */
`ifndef SPI_BRIDGE_CONSTS_SVH
`define SPI_BRIDGE_CONSTS_SVH

// word store geometry
`define STORE_WORDS 256
`define STORE_AW    $clog2(`STORE_WORDS)   // word index width, indices wrap at STORE_WORDS

// store response delay, clk cycles from a seen request to mem_ack
`define STORE_WAIT  3

// top address byte
`define REGION_MEM  8'h00   // word memory
`define REGION_CTRL 8'hFF   // 4-byte control register

// first byte of every SPI transaction
`define CMD_WRITE   8'h00
`define CMD_READ    8'h01

`endif

/* spi_bridge_pkg.sv */
`default_nettype none

package spi_bridge_pkg;

  // 32-bit SPI byte address, sent MSB first after the command byte
  // same word seen two ways, depending on the region byte
  typedef union packed {
    // memory region: byte address split into word index and half select
    struct packed {
      logic [7:0]  region;
      logic [22:0] word_idx;
      logic        byte_sel;    // 0 = high half, 1 = low half
    } mem;
    // control region: only the low two bits pick a register byte
    struct packed {
      logic [7:0]  region;
      logic [21:0] unused;
      logic [1:0]  reg_idx;     // 0 = least significant byte
    } ctrl;
  } spi_addr_t;

endpackage

`default_nettype wire

/* spi_rw_slave.sv */
`default_nettype none
`include "spi_bridge_consts.svh"

module spi_rw_slave
(
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       csn,
  input  wire                       sclk,
  input  wire                       mosi,
  input  wire  [7:0]                rdata,
  output logic                      miso,
  output logic                      rd,
  output logic                      wr,
  output spi_bridge_pkg::spi_addr_t addr,
  output logic [7:0]                wdata
);

  localparam logic [1:0] PH_CMD  = 2'd0;
  localparam logic [1:0] PH_ADDR = 2'd1;
  localparam logic [1:0] PH_DATA = 2'd2;

  logic [1:0]  sclk_sync;
  logic [1:0]  csn_sync;
  logic [1:0]  mosi_sync;
  logic        sclk_prev;
  logic        sclk_rise;
  logic        sclk_fall;
  logic        active;
  logic        byte_done;
  logic [7:0]  byte_in;

  logic [1:0]  phase;
  logic [2:0]  bit_cnt;
  logic [1:0]  addr_cnt;
  logic        is_read;
  logic        is_write;
  logic        used;        // a strobe already went out for addr_q
  logic [6:0]  shift_in;
  logic [7:0]  shift_out;
  logic [31:0] addr_q;

  // sclk is an ordinary pin, sampled in the clk domain
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      sclk_sync <= 2'b00;
      csn_sync  <= 2'b11;   // idle = deselected
      mosi_sync <= 2'b00;
      sclk_prev <= 1'b0;
    end
    else
    begin
      sclk_sync <= {sclk_sync[0], sclk};
      csn_sync  <= {csn_sync[0], csn};
      mosi_sync <= {mosi_sync[0], mosi};
      sclk_prev <= sclk_sync[1];
    end
  end

  assign sclk_rise = sclk_sync[1] & ~sclk_prev;
  assign sclk_fall = ~sclk_sync[1] & sclk_prev;
  assign active    = ~csn_sync[1];
  assign byte_in   = {shift_in, mosi_sync[1]};   // byte incl. the bit sampled now
  assign byte_done = active & sclk_rise & (bit_cnt == 3'd7);
  assign addr      = addr_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      phase     <= PH_CMD;
      bit_cnt   <= 3'd0;
      addr_cnt  <= 2'd0;
      is_read   <= 1'b0;
      is_write  <= 1'b0;
      used      <= 1'b0;
      rd        <= 1'b0;
      wr        <= 1'b0;
      shift_out <= 8'h00;
      miso      <= 1'b0;
      addr_q    <= 32'd0;
    end
    else
    begin
      rd <= 1'b0;
      wr <= 1'b0;
      if (!active)
      begin
        // csn high aborts, next byte is a command again
        phase     <= PH_CMD;
        bit_cnt   <= 3'd0;
        addr_cnt  <= 2'd0;
        used      <= 1'b0;
        shift_out <= 8'h00;
        miso      <= 1'b0;
      end
      else
      begin
        if (sclk_rise)
          bit_cnt <= bit_cnt + 3'd1;
        if (byte_done)
        begin
          shift_out <= 8'h00;
          case (phase)
            PH_CMD:
            begin
              is_read  <= (byte_in == `CMD_READ);
              is_write <= (byte_in == `CMD_WRITE);
              phase    <= PH_ADDR;
            end
            PH_ADDR:
            begin
              addr_q   <= {addr_q[23:0], byte_in};
              addr_cnt <= addr_cnt + 2'd1;
              if (addr_cnt == 2'd3)
              begin
                phase <= PH_DATA;
                if (is_read)
                begin
                  rd   <= 1'b1;   // fetch for the dummy slot
                  used <= 1'b1;
                end
              end
            end
            default:
            begin
              if (used)
                addr_q <= addr_q + 32'd1;
              used <= 1'b1;
              if (is_read)
              begin
                rd        <= 1'b1;
                shift_out <= rdata;   // fetched one slot ago
              end
              else if (is_write)
                wr <= 1'b1;
            end
          endcase
        end
        else if (sclk_fall)
        begin
          miso      <= shift_out[7];   // mode 0, change on falling edge
          shift_out <= {shift_out[6:0], 1'b0};
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (active && sclk_rise)
      shift_in <= byte_in[6:0];
    if (byte_done && phase == PH_DATA)
      wdata <= byte_in;
  end

  // rd and wr come from different commands
  a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst) !(rd && wr));

endmodule

`default_nettype wire

/* word_packer.sv */
`default_nettype none
`include "spi_bridge_consts.svh"

module word_packer
(
  input  wire                              clk,
  input  wire                              rst,
  input  wire                              rd,
  input  wire                              wr,
  input  wire spi_bridge_pkg::spi_addr_t   addr,
  input  wire  [7:0]                       wdata,
  input  wire                              mem_ack,
  input  wire  [15:0]                      mem_rdata,
  output logic [7:0]                       rdata,
  output logic                             mem_req,
  output logic                             mem_we,
  output logic [`STORE_AW-1:0]             mem_addr,
  output logic [15:0]                      mem_wdata,
  output logic [31:0]                      ctrl_word
);

  logic [7:0] hold [2];     // byte pair, index = byte select
  logic       rd_sel;       // half to return when the read completes
  logic       is_mem;
  logic       is_ctrl;
  logic       busy;
  logic       want_wr;
  logic       want_rd;
  logic       launch_wr;
  logic       launch_rd;

  assign is_mem  = (addr.mem.region == `REGION_MEM);
  assign is_ctrl = (addr.ctrl.region == `REGION_CTRL);
  assign busy    = mem_req | mem_ack;   // four-phase cycle still open

  // odd byte completes a word
  assign want_wr   = wr & is_mem & addr.mem.byte_sel;
  assign want_rd   = rd & is_mem;
  assign launch_wr = want_wr & ~busy;
  assign launch_rd = want_rd & ~busy;

  assign mem_wdata = {hold[0], hold[1]};   // even byte in the high half

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mem_req   <= 1'b0;
      mem_we    <= 1'b0;
      ctrl_word <= 32'd0;
      rdata     <= 8'h00;
    end
    else
    begin
      if (mem_req && mem_ack)
      begin
        mem_req <= 1'b0;
        if (!mem_we)
          rdata <= rd_sel ? mem_rdata[7:0] : mem_rdata[15:8];   // big-endian
      end

      if (wr && is_ctrl)
        ctrl_word[{addr.ctrl.reg_idx, 3'b000} +: 8] <= wdata;

      if (launch_wr)
      begin
        mem_req <= 1'b1;
        mem_we  <= 1'b1;
      end
      else if (launch_rd)
      begin
        mem_req <= 1'b1;
        mem_we  <= 1'b0;
      end

      if (rd && is_ctrl)
        rdata <= ctrl_word[{addr.ctrl.reg_idx, 3'b000} +: 8];
      else if (rd && !is_mem)
        rdata <= 8'h00;   // unmapped
    end
  end

  // payload, only meaningful while mem_req is up
  always_ff @(posedge clk)
  begin
    if (wr && is_mem)
      hold[addr.mem.byte_sel] <= wdata;
    if (launch_wr)
      mem_addr <= addr.mem.word_idx[`STORE_AW-1:0];   // wraps at STORE_WORDS
    else if (launch_rd)
    begin
      mem_addr <= addr.mem.word_idx[`STORE_AW-1:0];
      rd_sel   <= addr.mem.byte_sel;
    end
  end

  // sclk too fast for the store: a byte arrived before the last handshake closed
  a_no_overlap: assert property (@(posedge clk) disable iff (rst)
    (want_wr || want_rd) |-> !busy);

  // request and its payload stay put until acknowledged
  a_req_hold: assert property (@(posedge clk) disable iff (rst)
    (mem_req && !mem_ack) |=> (mem_req && $stable(mem_addr) && $stable(mem_we)
                               && $stable(mem_wdata)));

endmodule

`default_nettype wire

/* word_store.sv */
`default_nettype none
`include "spi_bridge_consts.svh"

module word_store
(
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  mem_req,
  input  wire                  mem_we,
  input  wire  [`STORE_AW-1:0] mem_addr,
  input  wire  [15:0]          mem_wdata,
  output logic                 mem_ack,
  output logic [15:0]          mem_rdata
);

  localparam int CW = $clog2(`STORE_WAIT + 1);

  logic [15:0]   mem [`STORE_WORDS];
  logic          busy;
  logic [CW-1:0] wait_cnt;
  logic          fire;        // access happens on this edge

  assign fire = busy && (wait_cnt == '0);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy     <= 1'b0;
      wait_cnt <= '0;
      mem_ack  <= 1'b0;
    end
    else
    begin
      if (mem_req && !busy && !mem_ack)
      begin
        busy     <= 1'b1;   // request seen
        wait_cnt <= CW'(`STORE_WAIT - 1);
      end
      else if (fire)
      begin
        busy    <= 1'b0;
        mem_ack <= 1'b1;
      end
      else if (busy)
        wait_cnt <= wait_cnt - 1'b1;
      else if (mem_ack && !mem_req)
        mem_ack <= 1'b0;    // last phase of the handshake
    end
  end

  always_ff @(posedge clk)
  begin
    if (fire)
    begin
      if (mem_we)
        mem[mem_addr] <= mem_wdata;
      else
        mem_rdata <= mem[mem_addr];   // valid together with mem_ack
    end
  end

  // ack only answers a live request
  a_ack_on_req: assert property (@(posedge clk) disable iff (rst)
    $rose(mem_ack) |-> mem_req);

endmodule

`default_nettype wire

/* spi_bridge_top.sv */
`default_nettype none
`include "spi_bridge_consts.svh"

module spi_bridge_top
(
  input  wire         clk,
  input  wire         rst,
  input  wire         csn,
  input  wire         sclk,
  input  wire         mosi,
  output logic        miso,
  output logic [31:0] ctrl_word
);

  import spi_bridge_pkg::*;

  spi_addr_t           addr;
  logic                rd;
  logic                wr;
  logic [7:0]          wdata;
  logic [7:0]          rdata;
  logic                mem_req;
  logic                mem_we;
  logic                mem_ack;
  logic [`STORE_AW-1:0] mem_addr;
  logic [15:0]         mem_wdata;
  logic [15:0]         mem_rdata;

  spi_rw_slave u_slave
  (
    .clk   (clk),
    .rst   (rst),
    .csn   (csn),
    .sclk  (sclk),
    .mosi  (mosi),
    .rdata (rdata),
    .miso  (miso),
    .rd    (rd),
    .wr    (wr),
    .addr  (addr),
    .wdata (wdata)
  );

  word_packer u_packer
  (
    .clk       (clk),
    .rst       (rst),
    .rd        (rd),
    .wr        (wr),
    .addr      (addr),
    .wdata     (wdata),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata),
    .rdata     (rdata),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .ctrl_word (ctrl_word)
  );

  // stands in for the SDRAM controller
  word_store u_store
  (
    .clk       (clk),
    .rst       (rst),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
  );

endmodule

`default_nettype wire

/* tb_spi_bridge.sv */
`default_nettype none
`include "spi_bridge_consts.svh"

module tb_spi_bridge;

  timeunit 1ns;
  timeprecision 100ps;

  import spi_bridge_pkg::*;

  localparam int AW        = `STORE_AW;
  localparam int SCLK_HALF = 4;   // clk per sclk half period, 8 clk per bit
  // worst-case bytes per test incl. command, address and dummy bytes
  localparam int TEST_BYTES     = 172 + 22 + 14 + 46 + 27 + 37;
  localparam int TIMEOUT_CYCLES = TEST_BYTES * 64 * 2;

  logic        clk = 1'b0;
  logic        rst;
  logic        csn;
  logic        sclk;
  logic        mosi;
  logic        miso;
  logic [31:0] ctrl_word;

  logic [15:0] model_mem [`STORE_WORDS];
  logic [7:0]  model_hold [2];
  logic [31:0] model_ctrl;

  logic [7:0]  wr_data [$];
  logic [7:0]  rd_data [$];
  int          checks;
  int          errors;
  int          test_errs;
  int          cycles;

  spi_bridge_top u_spi_bridge_top
  (
    .clk       (clk),
    .rst       (rst),
    .csn       (csn),
    .sclk      (sclk),
    .mosi      (mosi),
    .miso      (miso),
    .ctrl_word (ctrl_word)
  );

  always #4 clk = ~clk;

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("run timed out after %0d clk cycles without finishing the tests", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  function automatic logic [AW-1:0] word_of(spi_addr_t a);
    return AW'(a.mem.word_idx % `STORE_WORDS);   // word index wraps
  endfunction

  // same byte rules as the bridge: even byte held, odd byte stores the pair
  function automatic void model_write(spi_addr_t a, logic [7:0] d);
    if (a.mem.region == `REGION_MEM)
    begin
      model_hold[a.mem.byte_sel] = d;
      if (a.mem.byte_sel)
        model_mem[word_of(a)] = {model_hold[0], model_hold[1]};
    end
    else if (a.ctrl.region == `REGION_CTRL)
      model_ctrl[int'(a.ctrl.reg_idx) * 8 +: 8] = d;
  endfunction

  function automatic logic [7:0] model_read(spi_addr_t a);
    logic [15:0] w;
    if (a.mem.region == `REGION_MEM)
    begin
      w = model_mem[word_of(a)];
      return a.mem.byte_sel ? w[7:0] : w[15:8];   // even byte is the high half
    end
    if (a.ctrl.region == `REGION_CTRL)
      return model_ctrl[int'(a.ctrl.reg_idx) * 8 +: 8];
    return 8'h00;
  endfunction

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      test_errs++;
      $display("FAILED t=%0t %s got %02h expected %02h", $time, name, got, exp);
    end
  endtask

  task automatic check_ctrl(input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      test_errs++;
      $display("FAILED t=%0t ctrl_word got %08h expected %08h", $time, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    $display("test %s: %s, %0d mismatches", name, (test_errs == 0) ? "pass" : "fail",
             test_errs);
    test_errs = 0;
  endtask

  // one mode-0 byte, MSB first
  task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    logic [7:0] sh;
    sh = tx;
    rx = 8'h00;
    repeat (8)
    begin
      @(posedge clk);
      sclk <= 1'b0;
      mosi <= sh[7];
      sh = {sh[6:0], 1'b0};
      repeat (SCLK_HALF) @(posedge clk);
      sclk <= 1'b1;
      repeat (SCLK_HALF - 1) @(posedge clk);
      @(negedge clk);
      rx = {rx[6:0], miso};   // late in the high phase, miso settled
    end
  endtask

  task automatic spi_begin(input logic [7:0] cmd, input logic [31:0] a);
    logic [7:0]  rx;
    logic [31:0] sh;
    @(posedge clk);
    csn <= 1'b0;
    repeat (4) @(posedge clk);   // csn through the synchronizer
    spi_byte(cmd, rx);
    sh = a;
    repeat (4)
    begin
      spi_byte(sh[31:24], rx);
      sh = sh << 8;
    end
  endtask

  task automatic spi_end();
    @(posedge clk);
    sclk <= 1'b0;
    repeat (SCLK_HALF) @(posedge clk);
    csn <= 1'b1;
    repeat (8) @(posedge clk);
  endtask

  task automatic spi_write(input logic [31:0] a);
    logic [7:0] rx;
    spi_begin(`CMD_WRITE, a);
    foreach (wr_data[i])
    begin
      spi_byte(wr_data[i], rx);
      model_write(a + 32'(i), wr_data[i]);
    end
    spi_end();
  endtask

  task automatic spi_read(input logic [31:0] a, input int n);
    logic [7:0] rx;
    spi_begin(`CMD_READ, a);
    spi_byte(8'h00, rx);   // dummy slot, first word still being fetched
    rd_data.delete();
    repeat (n)
    begin
      spi_byte(8'h00, rx);
      rd_data.push_back(rx);
    end
    spi_end();
  endtask

  task automatic read_check(input logic [31:0] a, input int n);
    spi_read(a, n);
    foreach (rd_data[i])
      check_byte($sformatf("miso @%08h", a + 32'(i)), rd_data[i],
                 model_read(a + 32'(i)));
  endtask

  task automatic fill_random(input int n);
    wr_data.delete();
    repeat (n)
      wr_data.push_back(8'($urandom));
  endtask

  initial
  begin
    int unsigned w;
    int          n;
    logic [31:0] a;
    logic [31:0] first_a;
    void'($urandom(32'hbc6b));
    rst = 1'b1;
    csn = 1'b1;
    sclk = 1'b0;
    mosi = 1'b0;
    model_ctrl = 32'd0;
    model_hold[0] = 8'h00;
    model_hold[1] = 8'h00;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    repeat (4) @(posedge clk);

    for (int b = 0; b < 4; b++)
    begin
      w = $urandom % `STORE_WORDS;
      n = 2 * (1 + int'($urandom % 8));
      a = 32'(w) << 1;
      if (b == 0)
        first_a = a;
      fill_random(n);
      spi_write(a);
      read_check(a, n);
    end
    end_test("1 even-aligned bursts");

    // first word picks up the stale even byte
    w = 16 + $urandom % 200;
    a = (32'(w) << 1) | 32'd1;
    fill_random(5);
    spi_write(a);
    read_check(a - 32'd1, 6);
    end_test("2 odd start burst");

    w = $urandom % `STORE_WORDS;
    a = (32'(w) << 1) | 32'd1;
    fill_random(1);
    spi_write(a);
    read_check(a - 32'd1, 2);
    end_test("3 lone odd byte");

    repeat (6)
    begin
      fill_random(1);
      spi_write({`REGION_CTRL, 22'd0, 2'($urandom % 4)});
      check_ctrl(ctrl_word, model_ctrl);
    end
    read_check({`REGION_CTRL, 24'd0}, 4);
    end_test("4 control register");

    a = {8'(1 + $urandom % 254), first_a[23:0]};   // neither 00 nor FF
    read_check(a, 4);
    fill_random(4);
    spi_write(a);
    read_check(first_a, 2);
    check_ctrl(ctrl_word, model_ctrl);
    end_test("5 unmapped region");

    a = 32'((`STORE_WORDS - 2) * 2);
    fill_random(8);
    spi_write(a);
    read_check(a, 8);
    read_check(32'd0, 4);   // words 0 and 1 after the wrap
    end_test("6 word index wrap");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+.
spi_bridge_pkg.sv
spi_rw_slave.sv
word_packer.sv
word_store.sv
spi_bridge_top.sv
tb_spi_bridge.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the SPI bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
    -f project.f --top-module tb_spi_bridge -Mdir obj_dir -o sim_tb; then
  echo "verilator compile failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "^Test OK$"; then
  exit 0
fi
echo "pass message not found"
exit 1
